//--- source/rom_arb_pkg.sv
package rom_arb_pkg;

  ////////////////////
  // Data and address widths

  typedef logic [7:0]  byte_t;      // One SNES or MCU data byte
  typedef logic [15:0] rom_word_t;  // One PSRAM word
  typedef logic [23:0] snes_addr_t; // Byte address as seen by SNES and MCU
  typedef logic [22:0] rom_addr_t;  // PSRAM word address, byte address >> 1

  ////////////////////
  // Arbiter FSM

  // MCU access phases, the SNES owns the bus in IDLE
  typedef enum logic [2:0] {
    ARB_IDLE    = 3'd0,
    ARB_RD_ADDR = 3'd1, // MCU read address on the pins
    ARB_RD_END  = 3'd2,
    ARB_WR_ADDR = 3'd3, // MCU write, WE low
    ARB_WR_END  = 3'd4
  } arb_state_t;

endpackage

//--- source/rom_req_if.sv
`timescale 1ns/100ps

interface rom_req_if;
  import rom_arb_pkg::*;

  // Request side, held until done
  snes_addr_t addr;
  byte_t      wdata;
  logic       rd_pend;
  logic       wr_pend;

  // Completion side
  logic       done;    // One cycle in either END state
  byte_t      rdata;

  modport client (
    output addr, wdata, rd_pend, wr_pend,
    input  done, rdata
  );

  modport arbiter (
    input  addr, wdata, rd_pend, wr_pend,
    output done, rdata
  );

endinterface

//--- source/snes_bus_monitor.sv
`timescale 1ns/100ps

module snes_bus_monitor #(
  parameter int DEAD_TIMEOUT = 88000
) (
  input  logic clk2,
  input  logic arst_n,
  input  logic snes_cpu_clk,
  input  logic snes_romsel_n,
  output logic free_slot,
  output logic snes_dead,
  output logic snes_wake
);

  // Room for DEAD_TIMEOUT + 1 so the compare can trip
  localparam int CNT_W = $clog2(DEAD_TIMEOUT + 2);

  logic [4:0]       cpu_clk_sr; // Newest sample in bit 0
  logic             cycle_start;
  logic             cycle_end;
  logic [CNT_W-1:0] dead_cnt;

  ////////////////////
  // CPU clock edges

  always_ff @(posedge clk2 or negedge arst_n) begin
    if (!arst_n) begin
      cpu_clk_sr <= '0;
    end else begin
      cpu_clk_sr <= {cpu_clk_sr[3:0], snes_cpu_clk};
    end
  end

  assign cycle_start = (cpu_clk_sr[4:1] == 4'b0001); // Rising, two samples late
  assign cycle_end   = (cpu_clk_sr[4:1] == 4'b1110);

  // End of any cycle, or start of one that leaves ROM alone
  always_ff @(posedge clk2 or negedge arst_n) begin
    if (!arst_n) begin
      free_slot <= 1'b0;
    end else begin
      free_slot <= cycle_end | (cycle_start & snes_romsel_n);
    end
  end

  ////////////////////
  // Dead console detect

  always_ff @(posedge clk2 or negedge arst_n) begin
    if (!arst_n) begin
      dead_cnt <= '0;
    end else if (snes_cpu_clk) begin
      dead_cnt <= '0;
    end else if (dead_cnt <= CNT_W'(DEAD_TIMEOUT)) begin
      dead_cnt <= dead_cnt + CNT_W'(1); // Saturates one past the timeout
    end
  end

  always_ff @(posedge clk2 or negedge arst_n) begin
    if (!arst_n) begin
      snes_dead <= 1'b1; // Assume no console until its clock runs
    end else if (dead_cnt > CNT_W'(DEAD_TIMEOUT)) begin
      snes_dead <= 1'b1;
    end else if (snes_cpu_clk) begin
      snes_dead <= 1'b0;
    end
  end

  assign snes_wake = snes_dead & snes_cpu_clk;

endmodule

//--- source/mcu_access.sv
`timescale 1ns/100ps

module mcu_access (
  input  logic                   clk2,
  input  logic                   arst_n,
  input  logic                   mcu_rrq,
  input  logic                   mcu_wrq,
  input  rom_arb_pkg::snes_addr_t mcu_addr,
  input  rom_arb_pkg::byte_t      mcu_wdata,
  output logic                   mcu_rdy,
  output rom_arb_pkg::byte_t      mcu_rdata,
  rom_req_if.client              req
);

  ////////////////////
  // Pending flags and ready level

  // Read wins when both strobes land together
  always_ff @(posedge clk2 or negedge arst_n) begin
    if (!arst_n) begin
      req.rd_pend <= 1'b0;
      req.wr_pend <= 1'b0;
      mcu_rdy     <= 1'b1;
    end else if (mcu_rrq) begin
      req.rd_pend <= 1'b1;
      mcu_rdy     <= 1'b0;
    end else if (mcu_wrq) begin
      req.wr_pend <= 1'b1;
      mcu_rdy     <= 1'b0;
    end else if (req.done) begin
      req.rd_pend <= 1'b0; // Access finished
      req.wr_pend <= 1'b0;
      mcu_rdy     <= 1'b1;
    end
  end

  ////////////////////
  // Request payload

  always_ff @(posedge clk2) begin
    if (mcu_rrq || mcu_wrq) begin
      req.addr <= mcu_addr; // Re-latched by a strobe while busy
    end
    if (mcu_wrq) begin
      req.wdata <= mcu_wdata;
    end
  end

  always_ff @(posedge clk2) begin
    if (req.done) begin
      mcu_rdata <= req.rdata;
    end
  end

endmodule

//--- source/rom_arbiter.sv
`timescale 1ns/100ps

module rom_arbiter #(
  parameter int ROM_CYCLE_LEN = 7
) (
  input  logic                    clk2,
  input  logic                    arst_n,
  input  logic                    free_slot,
  input  logic                    snes_dead,
  input  logic                    snes_wake,
  input  rom_arb_pkg::snes_addr_t snes_addr,
  input  rom_arb_pkg::snes_addr_t rom_mask,
  input  logic                    snes_read,
  inout  wire rom_arb_pkg::byte_t snes_data,
  inout  wire rom_arb_pkg::rom_word_t rom_data,
  output rom_arb_pkg::rom_addr_t  rom_addr,
  output logic                    rom_we_n,
  output logic                    rom_bhe_n,
  output logic                    rom_ble_n,
  rom_req_if.arbiter              req
);
  import rom_arb_pkg::*;

  localparam int DLY_W = (ROM_CYCLE_LEN > 0) ? $clog2(ROM_CYCLE_LEN + 1) : 1;

  arb_state_t       state;
  logic [DLY_W-1:0] delay;
  logic             mcu_hit;
  logic             wr_hit;
  snes_addr_t       sel_addr;
  byte_t            lane_byte;

  ////////////////////
  // Access FSM

  always_ff @(posedge clk2 or negedge arst_n) begin
    if (!arst_n) begin
      state <= ARB_IDLE;
      delay <= '0;
    end else if (snes_wake) begin
      state <= ARB_IDLE; // SNES back, abort and retry later
    end else begin
      case (state)
        ARB_IDLE: begin
          if (free_slot || snes_dead) begin
            if (req.rd_pend) begin
              state <= ARB_RD_ADDR;
              delay <= DLY_W'(ROM_CYCLE_LEN);
            end else if (req.wr_pend) begin
              state <= ARB_WR_ADDR;
              delay <= DLY_W'(ROM_CYCLE_LEN);
            end
          end
        end
        ARB_RD_ADDR, ARB_WR_ADDR: begin
          delay <= delay - DLY_W'(1);
          if (delay == '0) begin
            state <= (state == ARB_RD_ADDR) ? ARB_RD_END : ARB_WR_END;
          end
        end
        default: state <= ARB_IDLE; // Both END states
      endcase
    end
  end

  assign req.done = (state == ARB_RD_END) || (state == ARB_WR_END);

  // Last sample before END is the one handed back
  always_ff @(posedge clk2) begin
    if (state == ARB_RD_ADDR) begin
      req.rdata <= lane_byte;
    end
  end

  ////////////////////
  // PSRAM pins

  assign wr_hit   = (state == ARB_WR_ADDR);
  assign mcu_hit  = wr_hit || (state == ARB_RD_ADDR);
  assign sel_addr = mcu_hit ? req.addr : (snes_addr & rom_mask);

  assign rom_addr  = sel_addr[23:1];
  assign rom_bhe_n = sel_addr[0];   // Even address lives in the upper byte
  assign rom_ble_n = ~sel_addr[0];
  assign rom_we_n  = ~wr_hit;

  assign lane_byte = sel_addr[0] ? rom_data[7:0] : rom_data[15:8];

  assign rom_data[7:0]  = (wr_hit && sel_addr[0])  ? req.wdata : 8'bz;
  assign rom_data[15:8] = (wr_hit && !sel_addr[0]) ? req.wdata : 8'bz;

  assign snes_data = snes_read ? 8'bz : lane_byte; // Straight through, no clock

endmodule

//--- source/cart_rom_top.sv
`timescale 1ns/100ps

module cart_rom_top #(
  parameter int DEAD_TIMEOUT  = 88000,
  parameter int ROM_CYCLE_LEN = 7
) (
  input  logic                      clk2,
  input  logic                      arst_n,
  input  rom_arb_pkg::snes_addr_t   snes_addr,
  input  rom_arb_pkg::snes_addr_t   rom_mask,
  input  logic                      snes_read,
  input  logic                      snes_romsel_n,
  input  logic                      snes_cpu_clk,
  input  logic                      mcu_rrq,
  input  logic                      mcu_wrq,
  input  rom_arb_pkg::snes_addr_t   mcu_addr,
  input  rom_arb_pkg::byte_t        mcu_wdata,
  inout  wire rom_arb_pkg::byte_t   snes_data,
  inout  wire rom_arb_pkg::rom_word_t rom_data,
  output logic                      mcu_rdy,
  output rom_arb_pkg::byte_t        mcu_rdata,
  output rom_arb_pkg::rom_addr_t    rom_addr,
  output logic                      rom_we_n,
  output logic                      rom_bhe_n,
  output logic                      rom_ble_n
);

  logic free_slot;
  logic snes_dead;
  logic snes_wake;

  rom_req_if i_req ();

  // SNES bus timing
  snes_bus_monitor #(
    .DEAD_TIMEOUT (DEAD_TIMEOUT)
  ) i_snes_bus_monitor (
    .clk2          (clk2),
    .arst_n        (arst_n),
    .snes_cpu_clk  (snes_cpu_clk),
    .snes_romsel_n (snes_romsel_n),
    .free_slot     (free_slot),
    .snes_dead     (snes_dead),
    .snes_wake     (snes_wake)
  );

  mcu_access i_mcu_access (
    .clk2      (clk2),
    .arst_n    (arst_n),
    .mcu_rrq   (mcu_rrq),
    .mcu_wrq   (mcu_wrq),
    .mcu_addr  (mcu_addr),
    .mcu_wdata (mcu_wdata),
    .mcu_rdy   (mcu_rdy),
    .mcu_rdata (mcu_rdata),
    .req       (i_req.client)
  );

  rom_arbiter #(
    .ROM_CYCLE_LEN (ROM_CYCLE_LEN)
  ) i_rom_arbiter (
    .clk2      (clk2),
    .arst_n    (arst_n),
    .free_slot (free_slot),
    .snes_dead (snes_dead),
    .snes_wake (snes_wake),
    .snes_addr (snes_addr),
    .rom_mask  (rom_mask),
    .snes_read (snes_read),
    .snes_data (snes_data),
    .rom_data  (rom_data),
    .rom_addr  (rom_addr),
    .rom_we_n  (rom_we_n),
    .rom_bhe_n (rom_bhe_n),
    .rom_ble_n (rom_ble_n),
    .req       (i_req.arbiter)
  );

endmodule

//--- dv/psram_model.sv
`timescale 1ns/100ps

module psram_model #(
  parameter int AW = 10
) (
  input  rom_arb_pkg::rom_addr_t      addr,
  inout  wire rom_arb_pkg::rom_word_t data,
  input  logic                        we_n,
  input  logic                        bhe_n,
  input  logic                        ble_n
);
  import rom_arb_pkg::*;

  // Only the low AW word address bits decode, upper ones alias
  rom_word_t     mem [0:2**AW-1];
  logic [AW-1:0] idx;

  assign idx  = addr[AW-1:0];
  assign data = we_n ? mem[idx] : 'z; // Both lanes on a read

  ////////////////////
  // Write cycle

  // Address and lane data are stable for the whole WE low phase
  always begin
    @(negedge we_n);
    #1;
    if (!we_n) begin
      if (!bhe_n) begin
        mem[idx][15:8] = data[15:8];
      end
      if (!ble_n) begin
        mem[idx][7:0] = data[7:0];
      end
    end
  end

endmodule

//--- dv/tb_cart_rom.sv
`timescale 1ns/100ps

module tb_cart_rom;
  import rom_arb_pkg::*;

  localparam int DEAD_TO   = 64;
  localparam int MEM_AW    = 10;
  localparam int RDY_LIMIT = 200;
  localparam int SEED      = 44500;
  localparam int N_TESTS   = 6;
  localparam int MAX_ACC   = 30;
  localparam int ACC_CYC   = 40;
  // Twice the access budget plus room for the dead console waits
  localparam int CYCLE_LIMIT = 2 * N_TESTS * MAX_ACC * ACC_CYC + 5600;

  logic           clk2;
  logic           arst_n;
  snes_addr_t     snes_addr;
  snes_addr_t     rom_mask;
  logic           snes_read;
  logic           snes_romsel_n;
  logic           snes_cpu_clk;
  logic           mcu_rrq;
  logic           mcu_wrq;
  snes_addr_t     mcu_addr;
  byte_t          mcu_wdata;
  wire byte_t     snes_data;
  wire rom_word_t rom_data;
  logic           mcu_rdy;
  byte_t          mcu_rdata;
  rom_addr_t      rom_addr;
  logic           rom_we_n;
  logic           rom_bhe_n;
  logic           rom_ble_n;

  logic  cpu_run;    // CPU clock generator on
  logic  snes_run;   // Random SNES reads each cycle
  logic  chk_en;     // SNES read compare on
  int    cpu_div;
  int    cycles;
  int    errors;
  int    snes_errs;
  int    snes_checks;
  int    tests_passed;
  int    tests_failed;
  byte_t shadow [0:2**(MEM_AW+1)-1]; // Expected memory with one entry per byte address

  cart_rom_top #(
    .DEAD_TIMEOUT (DEAD_TO)
  ) i_cart_rom_top (
    .clk2          (clk2),
    .arst_n        (arst_n),
    .snes_addr     (snes_addr),
    .rom_mask      (rom_mask),
    .snes_read     (snes_read),
    .snes_romsel_n (snes_romsel_n),
    .snes_cpu_clk  (snes_cpu_clk),
    .mcu_rrq       (mcu_rrq),
    .mcu_wrq       (mcu_wrq),
    .mcu_addr      (mcu_addr),
    .mcu_wdata     (mcu_wdata),
    .snes_data     (snes_data),
    .rom_data      (rom_data),
    .mcu_rdy       (mcu_rdy),
    .mcu_rdata     (mcu_rdata),
    .rom_addr      (rom_addr),
    .rom_we_n      (rom_we_n),
    .rom_bhe_n     (rom_bhe_n),
    .rom_ble_n     (rom_ble_n)
  );

  psram_model #(
    .AW (MEM_AW)
  ) i_psram_model (
    .addr  (rom_addr),
    .data  (rom_data),
    .we_n  (rom_we_n),
    .bhe_n (rom_bhe_n),
    .ble_n (rom_ble_n)
  );

  always #5 clk2 = ~clk2;

  ////////////////////
  // Reference model

  function automatic snes_addr_t ref_mask(input snes_addr_t a, input snes_addr_t m);
    return a & m;
  endfunction

  // Even byte address sits in the upper lane
  function automatic byte_t ref_rom_byte(input snes_addr_t a);
    rom_word_t w;
    w = i_psram_model.mem[a[MEM_AW:1]];
    return a[0] ? w[7:0] : w[15:8];
  endfunction

  ////////////////////
  // Background processes

  always @(negedge clk2) begin
    if (cpu_run) begin
      if (cpu_div == 5) begin
        cpu_div      <= 0;
        snes_cpu_clk <= ~snes_cpu_clk; // Toggle every 6 cycles
      end else begin
        cpu_div <= cpu_div + 1;
      end
    end
  end

  always @(negedge clk2) begin
    if (snes_run) begin
      snes_addr     <= $urandom;
      rom_mask      <= $urandom;
      snes_romsel_n <= $urandom_range(0, 1);
    end
  end

  // SNES read compare while the pins carry the SNES address
  always @(negedge clk2) begin : snes_compare
    snes_addr_t m;
    m = ref_mask(snes_addr, rom_mask);
    if (chk_en && !snes_read && rom_we_n && rom_addr == m[23:1] && rom_bhe_n == m[0]) begin
      snes_checks = snes_checks + 1;
      if (snes_data !== ref_rom_byte(m)) begin
        $display("FAIL snes_data: got %h expected %h at %h", snes_data, ref_rom_byte(m), m);
        snes_errs = snes_errs + 1;
      end
    end
  end

  always @(posedge clk2) begin
    cycles <= cycles + 1;
    if (cycles >= CYCLE_LIMIT) begin
      $display("Timeout, run stopped after %0d cycles", cycles);
      $display("Something failed");
      $finish;
    end
  end

  ////////////////////
  // MCU request tasks

  task automatic issue_request(input logic wr, input snes_addr_t a, input byte_t d);
    @(negedge clk2);
    mcu_addr  <= a;
    mcu_wdata <= d;
    mcu_wrq   <= wr;
    mcu_rrq   <= !wr;
    @(negedge clk2);
    mcu_wrq <= 1'b0;
    mcu_rrq <= 1'b0;
  endtask

  task automatic wait_ready(output bit ok);
    int n;
    n = 0;
    while (!mcu_rdy && n < RDY_LIMIT) begin
      @(negedge clk2);
      n++;
    end
    ok = mcu_rdy;
  endtask

  task automatic run_write(input snes_addr_t a, input byte_t d);
    bit ok;
    shadow[a[MEM_AW:0]] = d;
    issue_request(1'b1, a, d);
    wait_ready(ok);
    if (!ok) begin
      $display("MCU write to %h did not finish within %0d cycles", a, RDY_LIMIT);
      errors++;
    end
  endtask

  task automatic run_read(input snes_addr_t a);
    bit ok;
    issue_request(1'b0, a, 8'h00);
    wait_ready(ok);
    if (!ok) begin
      $display("MCU read from %h did not finish within %0d cycles", a, RDY_LIMIT);
      errors++;
    end else if (mcu_rdata !== shadow[a[MEM_AW:0]]) begin
      $display("FAIL mcu_rdata: got %h expected %h at %h", mcu_rdata,
               shadow[a[MEM_AW:0]], a);
      errors++;
    end
  endtask

  task automatic report_test(input string name, input int e0);
    if (errors == e0) begin
      tests_passed++;
      $display("Test %-26s passed", name);
    end else begin
      tests_failed++;
      $display("Test %-26s failed with %0d errors", name, errors - e0);
    end
  endtask

  ////////////////////
  // Test sequence

  initial begin
    int         seed_ret;
    int         e0;
    bit         ok;
    rom_word_t  w;
    snes_addr_t a;
    snes_addr_t m;
    snes_addr_t ma;
    byte_t      d;
    snes_addr_t wr_addrs[$];

    seed_ret      = $urandom(SEED);
    clk2          = 1'b0;
    arst_n        = 1'b0;
    snes_addr     = '0;
    rom_mask      = '1;
    snes_read     = 1'b1;
    snes_romsel_n = 1'b1;
    snes_cpu_clk  = 1'b0;
    mcu_rrq       = 1'b0;
    mcu_wrq       = 1'b0;
    mcu_addr      = '0;
    mcu_wdata     = '0;
    cpu_run       = 1'b0;
    snes_run      = 1'b0;
    chk_en        = 1'b0;
    cpu_div       = 0;
    cycles        = 0;
    errors        = 0;
    snes_errs     = 0;
    snes_checks   = 0;
    tests_passed  = 0;
    tests_failed  = 0;

    for (int i = 0; i < 2**MEM_AW; i++) begin
      w = $urandom;
      i_psram_model.mem[i] = w;
      shadow[2*i]          = w[15:8];
      shadow[2*i+1]        = w[7:0];
    end

    repeat (5) @(negedge clk2);
    arst_n <= 1'b1;

    // 1. Reset state
    e0 = errors;
    @(negedge clk2);
    if (mcu_rdy !== 1'b1) begin
      $display("FAIL mcu_rdy: got %h expected 1", mcu_rdy);
      errors++;
    end
    if (rom_we_n !== 1'b1) begin
      $display("FAIL rom_we_n: got %h expected 1", rom_we_n);
      errors++;
    end
    if (snes_data !== 8'hzz) begin
      $display("FAIL snes_data: got %h expected zz", snes_data);
      errors++;
    end
    report_test("reset state", e0);

    // 2. Combinational SNES reads
    e0 = errors;
    snes_read <= 1'b0;
    for (int i = 0; i < MAX_ACC; i++) begin
      @(negedge clk2);
      a = $urandom;
      m = $urandom;
      snes_addr <= a;
      rom_mask  <= m;
      @(negedge clk2);
      ma = ref_mask(a, m);
      if (snes_data !== ref_rom_byte(ma)) begin
        $display("FAIL snes_data: got %h expected %h at %h", snes_data, ref_rom_byte(ma), ma);
        errors++;
      end
      if (rom_addr !== ma[23:1]) begin
        $display("FAIL rom_addr: got %h expected %h", rom_addr, ma[23:1]);
        errors++;
      end
      if (rom_bhe_n !== ma[0] || rom_ble_n !== !ma[0]) begin
        $display("FAIL rom_bhe_n/rom_ble_n: got %h/%h expected %h/%h",
                 rom_bhe_n, rom_ble_n, ma[0], !ma[0]);
        errors++;
      end
    end
    snes_read <= 1'b1;
    report_test("snes reads", e0);

    // 3. MCU writes with the console dead
    e0 = errors;
    repeat (DEAD_TO + 4) @(negedge clk2);
    for (int i = 0; i < 20; i++) begin
      a = $urandom;
      d = $urandom;
      wr_addrs.push_back(a);
      run_write(a, d);
    end
    foreach (wr_addrs[i]) begin
      if (ref_rom_byte(wr_addrs[i]) !== shadow[wr_addrs[i][MEM_AW:0]]) begin
        $display("FAIL mem[%h]: got %h expected %h", wr_addrs[i],
                 ref_rom_byte(wr_addrs[i]), shadow[wr_addrs[i][MEM_AW:0]]);
        errors++;
      end
    end
    report_test("mcu writes, dead snes", e0);

    // 4. MCU reads from random and written bytes
    e0 = errors;
    for (int i = 0; i < 20; i++) begin
      a = (i % 2) ? wr_addrs[i] : snes_addr_t'($urandom);
      run_read(a);
    end
    report_test("mcu reads, dead snes", e0);

    // 5. MCU traffic against a running console
    e0 = errors;
    snes_errs   = 0;
    snes_checks = 0;
    snes_read <= 1'b0;
    snes_run  <= 1'b1;
    chk_en    <= 1'b1;
    cpu_div   <= 0;
    cpu_run   <= 1'b1;
    for (int i = 0; i < 24; i++) begin
      a = $urandom;
      d = $urandom;
      if ($urandom_range(0, 1)) begin
        run_write(a, d);
      end else begin
        run_read(a);
      end
    end
    chk_en    <= 1'b0;
    snes_run  <= 1'b0;
    snes_read <= 1'b1;
    cpu_run   <= 1'b0;
    @(negedge clk2);
    snes_cpu_clk <= 1'b0;
    errors = errors + snes_errs;
    if (snes_checks == 0) begin
      $display("No SNES read was checked while the console was running");
      errors++;
    end
    report_test("shared bus, live snes", e0);

    // 6. Console wakes in the middle of a write
    e0 = errors;
    repeat (DEAD_TO + 4) @(negedge clk2);
    a = $urandom;
    d = $urandom;
    shadow[a[MEM_AW:0]] = d;
    issue_request(1'b1, a, d);
    repeat (2) @(negedge clk2);
    if (rom_we_n !== 1'b0) begin
      $display("The MCU write was not on the ROM bus when the console woke");
      errors++;
    end
    snes_cpu_clk <= 1'b1;
    cpu_div      <= 0;
    cpu_run      <= 1'b1;
    @(negedge clk2);
    if (rom_we_n !== 1'b1) begin
      $display("The MCU write was not aborted when the console woke");
      errors++;
    end
    wait_ready(ok);
    if (!ok) begin
      $display("MCU write after wake did not finish within %0d cycles", RDY_LIMIT);
      errors++;
    end else if (ref_rom_byte(a) !== d) begin
      $display("FAIL mem[%h]: got %h expected %h", a, ref_rom_byte(a), d);
      errors++;
    end
    cpu_run <= 1'b0;
    @(negedge clk2);
    snes_cpu_clk <= 1'b0;
    report_test("wake restart", e0);

    $display("Tests passed: %0d, failed: %0d", tests_passed, tests_failed);
    if (tests_failed == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

//--- vlog.f
source/rom_arb_pkg.sv
source/rom_req_if.sv
source/snes_bus_monitor.sv
source/mcu_access.sv
source/rom_arbiter.sv
source/cart_rom_top.sv
dv/psram_model.sv
dv/tb_cart_rom.sv
